// ==== hdl/param_keys.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "video_params.svh"

module param_keys
  import video_pkg::*;
(
  input  logic       clk_50m,
  input  logic       locked,
  input  logic       key_left,
  input  logic       key_right,
  input  logic       key_restore,
  output param_idx_t led_index
);

  localparam param_idx_t IDX_LAST  = param_idx_t'(`PARAM_COUNT - 1);
  localparam param_idx_t IDX_COUNT = param_idx_t'(`PARAM_COUNT);

  // bit order is {restore, right, left}
  logic [2:0] key_meta;
  logic [2:0] key_sync;
  logic [2:0] key_last;
  logic [2:0] key_rise;
  key_cmd_t   cmd;

  // --------------------
  // synchronize and find rising edges
  // --------------------
  always_ff @(posedge clk_50m or negedge locked) begin
    if (!locked) begin
      key_meta <= '0;
      key_sync <= '0;
      key_last <= '0;
    end else begin
      key_meta <= {key_restore, key_right, key_left};
      key_sync <= key_meta;
      key_last <= key_sync;
    end
  end

  assign key_rise = key_sync & ~key_last;

  // restore beats everything, left with right cancels out
  always_comb begin
    cmd = KEY_NONE;
    if (key_rise[2]) begin
      cmd = KEY_RESTORE;
    end else if (key_rise[1] && !key_rise[0]) begin
      cmd = KEY_NEXT;
    end else if (key_rise[0] && !key_rise[1]) begin
      cmd = KEY_PREV;
    end
  end

  // --------------------
  // wrapping index
  // --------------------
  always_ff @(posedge clk_50m or negedge locked) begin
    if (!locked) begin
      led_index <= '0;
    end else begin
      case (cmd)
        KEY_RESTORE: led_index <= '0;
        KEY_NEXT:    led_index <= (led_index == IDX_LAST) ? '0 : led_index + 1'b1;
        KEY_PREV:    led_index <= (led_index == '0) ? IDX_LAST : led_index - 1'b1;
        default:     led_index <= led_index;
      endcase
    end
  end

  a_index_range: assert property (
    @(posedge clk_50m) disable iff (!locked)
    led_index < IDX_COUNT
  ) else $error("led_index out of range");

endmodule

`default_nettype wire

// ==== hdl/periph_reset_gen.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "video_params.svh"

module periph_reset_gen (
  input  logic clk_50m,
  input  logic locked,
  output logic periph_rstn
);

  localparam int CNT_W = $clog2(`RESET_DELAY + 1);
  localparam logic [CNT_W-1:0] CNT_DONE = CNT_W'(`RESET_DELAY);

  logic [CNT_W-1:0] dly_cnt;  // cycles since lock
  logic             rst_ready;

  // counter stops at the end value so the release holds
  always_ff @(posedge clk_50m or negedge locked) begin
    if (!locked) begin
      dly_cnt   <= '0;
      rst_ready <= 1'b0;
    end else if (dly_cnt == CNT_DONE) begin
      rst_ready <= 1'b1;
    end else begin
      dly_cnt   <= dly_cnt + 1'b1;
      rst_ready <= 1'b0;
    end
  end

  // one more stage before the reset leaves the block
  always_ff @(posedge clk_50m or negedge locked) begin
    if (!locked) begin
      periph_rstn <= 1'b0;
    end else begin
      periph_rstn <= rst_ready;
    end
  end

  // once released, the peripherals stay out of reset
  a_rstn_holds: assert property (
    @(posedge clk_50m) disable iff (!locked)
    periph_rstn |=> periph_rstn
  ) else $error("periph_rstn dropped while locked");

endmodule

`default_nettype wire

// ==== hdl/rgb565_expand.sv ====
`timescale 1ns/1ps
`default_nettype none

module rgb565_expand
  import video_pkg::*;
(
  input  logic    clk_50m,
  input  logic    locked,
  input  logic    periph_rstn,
  input  logic    raw_hs,
  input  logic    raw_vs,
  input  logic    raw_de,
  input  rgb565_t pixel_data,
  output logic    hs_out,
  output logic    vs_out,
  output logic    de_out,
  output chan8_t  r_out,
  output chan8_t  g_out,
  output chan8_t  b_out
);

  // syncs take the same single stage as the pixel
  always_ff @(posedge clk_50m or negedge locked) begin
    if (!locked) begin
      hs_out <= 1'b0;
      vs_out <= 1'b0;
      de_out <= 1'b0;
    end else if (!periph_rstn) begin
      hs_out <= 1'b0;
      vs_out <= 1'b0;
      de_out <= 1'b0;
    end else begin
      hs_out <= raw_hs;
      vs_out <= raw_vs;
      de_out <= raw_de;
    end
  end

  // top bits refill the low end so full scale maps to 8'hff
  always_ff @(posedge clk_50m) begin
    if (periph_rstn && raw_de) begin
      r_out <= {pixel_data[15:11], pixel_data[15:13]};
      g_out <= {pixel_data[10:5], pixel_data[10:9]};
      b_out <= {pixel_data[4:0], pixel_data[4:2]};
    end else begin
      r_out <= '0;  // black in blanking
      g_out <= '0;
      b_out <= '0;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/video_out_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_out_top
  import video_pkg::*;
(
  input  logic       clk_50m,
  input  logic       locked,       // pll lock, active low reset
  input  logic       cam_vs,
  input  rgb565_t    pixel_data,   // valid the cycle after pixel_rd
  input  logic       key_left,
  input  logic       key_right,
  input  logic       key_restore,
  output logic       periph_rstn,
  output logic       frame_vs,
  output logic       pixel_rd,
  output logic       hs_out,
  output logic       vs_out,
  output logic       de_out,
  output chan8_t     r_out,
  output chan8_t     g_out,
  output chan8_t     b_out,
  output param_idx_t led_index
);

  logic raw_hs;
  logic raw_vs;
  logic raw_de;

  // --------------------
  // reset and write side
  // --------------------
  periph_reset_gen u_periph_reset_gen (
    .clk_50m     (clk_50m),
    .locked      (locked),
    .periph_rstn (periph_rstn)
  );

  vsync_delay u_vsync_delay (
    .clk_50m     (clk_50m),
    .locked      (locked),
    .periph_rstn (periph_rstn),
    .cam_vs      (cam_vs),
    .frame_vs    (frame_vs)
  );

  // --------------------
  // display output
  // --------------------
  video_timing_gen u_video_timing_gen (
    .clk_50m     (clk_50m),
    .locked      (locked),
    .periph_rstn (periph_rstn),
    .pixel_rd    (pixel_rd),
    .raw_hs      (raw_hs),
    .raw_vs      (raw_vs),
    .raw_de      (raw_de)
  );

  rgb565_expand u_rgb565_expand (
    .clk_50m     (clk_50m),
    .locked      (locked),
    .periph_rstn (periph_rstn),
    .raw_hs      (raw_hs),
    .raw_vs      (raw_vs),
    .raw_de      (raw_de),
    .pixel_data  (pixel_data),
    .hs_out      (hs_out),
    .vs_out      (vs_out),
    .de_out      (de_out),
    .r_out       (r_out),
    .g_out       (g_out),
    .b_out       (b_out)
  );

  param_keys u_param_keys (
    .clk_50m     (clk_50m),
    .locked      (locked),
    .key_left    (key_left),
    .key_right   (key_right),
    .key_restore (key_restore),
    .led_index   (led_index)
  );

endmodule

`default_nettype wire

// ==== hdl/video_params.svh ====
`ifndef VIDEO_PARAMS_SVH
`define VIDEO_PARAMS_SVH

// --------------------
// horizontal timing in pixel clocks
// 720p panel uses 1280 / 110 / 40 / 220 / 1650
// --------------------
`define H_ACT       16    // visible pixels per line
`define H_FP        2     // front porch after active
`define H_SYNC      3     // hsync pulse width
`define H_BP        4     // back porch before active
`define H_TOTAL     25    // whole line length

// --------------------
// vertical timing in lines
// 720p panel uses 720 / 5 / 5 / 20 / 750
// --------------------
`define V_ACT       6     // visible lines per frame
`define V_FP        1     // lines after active
`define V_SYNC      2     // vsync pulse in lines
`define V_BP        2     // lines before active
`define V_TOTAL     11    // whole frame length

// --------------------
// delays and key control
// --------------------
`define RESET_DELAY 20    // lock to release count, 10000 on the board
`define VS_DELAY    40    // filter latency in cycles, 2560 on the board
`define PARAM_COUNT 10    // selectable parameter slots

`endif

// ==== hdl/video_pkg.sv ====
`default_nettype none

package video_pkg;

  // horizontal phase, in line order
  typedef enum logic [1:0] {
    HP_SYNC,
    HP_BACK,
    HP_ACTIVE,
    HP_FRONT
  } hphase_t;

  // decoded key action
  typedef enum logic [1:0] {
    KEY_NONE,
    KEY_PREV,
    KEY_NEXT,
    KEY_RESTORE
  } key_cmd_t;

  typedef logic [15:0] rgb565_t;     // r[15:11] g[10:5] b[4:0]
  typedef logic [7:0]  chan8_t;      // one output colour channel
  typedef logic [3:0]  param_idx_t;  // selected parameter slot
  typedef logic [11:0] hcount_t;
  typedef logic [11:0] vcount_t;

endpackage

`default_nettype wire

// ==== hdl/video_timing_gen.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "video_params.svh"

module video_timing_gen
  import video_pkg::*;
(
  input  logic clk_50m,
  input  logic locked,
  input  logic periph_rstn,
  output logic pixel_rd,
  output logic raw_hs,
  output logic raw_vs,
  output logic raw_de
);

  // last count of each horizontal phase
  localparam hcount_t H_SYNC_END = hcount_t'(`H_SYNC - 1);
  localparam hcount_t H_BP_END   = hcount_t'(`H_SYNC + `H_BP - 1);
  localparam hcount_t H_ACT_END  = hcount_t'(`H_SYNC + `H_BP + `H_ACT - 1);
  localparam hcount_t H_LAST     = hcount_t'(`H_TOTAL - 1);

  localparam vcount_t V_SYNC_END  = vcount_t'(`V_SYNC);
  localparam vcount_t V_ACT_START = vcount_t'(`V_SYNC + `V_BP);
  localparam vcount_t V_ACT_STOP  = vcount_t'(`V_SYNC + `V_BP + `V_ACT);
  localparam vcount_t V_LAST      = vcount_t'(`V_TOTAL - 1);

  hcount_t hcnt;
  vcount_t vcnt;
  hphase_t hphase;      // phase of the current hcnt
  hphase_t hphase_nxt;  // phase of the next hcnt
  logic    line_end;
  logic    v_active;

  assign line_end = (hcnt == H_LAST);
  assign v_active = (vcnt >= V_ACT_START) && (vcnt < V_ACT_STOP);

  // --------------------
  // horizontal phase sequence
  // --------------------
  always_comb begin
    hphase_nxt = hphase;
    case (hphase)
      HP_SYNC: begin
        if (hcnt == H_SYNC_END) hphase_nxt = HP_BACK;
      end
      HP_BACK: begin
        if (hcnt == H_BP_END) hphase_nxt = HP_ACTIVE;
      end
      HP_ACTIVE: begin
        if (hcnt == H_ACT_END) hphase_nxt = HP_FRONT;
      end
      HP_FRONT: begin
        if (line_end) hphase_nxt = HP_SYNC;
      end
      default: hphase_nxt = HP_SYNC;
    endcase
  end

  // --------------------
  // counters and registered outputs
  // --------------------
  always_ff @(posedge clk_50m or negedge locked) begin
    if (!locked) begin
      hcnt     <= '0;
      vcnt     <= '0;
      hphase   <= HP_SYNC;
      raw_hs   <= 1'b0;
      raw_vs   <= 1'b0;
      raw_de   <= 1'b0;
      pixel_rd <= 1'b0;
    end else if (!periph_rstn) begin
      hcnt     <= '0;
      vcnt     <= '0;
      hphase   <= HP_SYNC;
      raw_hs   <= 1'b0;
      raw_vs   <= 1'b0;
      raw_de   <= 1'b0;
      pixel_rd <= 1'b0;
    end else begin
      hphase <= hphase_nxt;
      if (line_end) begin
        hcnt <= '0;
        vcnt <= (vcnt == V_LAST) ? '0 : vcnt + 1'b1;
      end else begin
        hcnt <= hcnt + 1'b1;
      end
      raw_hs   <= (hcnt <= H_SYNC_END);
      raw_vs   <= (vcnt < V_SYNC_END);                 // whole lines
      raw_de   <= (hphase == HP_ACTIVE) && v_active;
      pixel_rd <= (hphase_nxt == HP_ACTIVE) && v_active; // one pixel early
    end
  end

  a_de_not_hs: assert property (
    @(posedge clk_50m) disable iff (!locked)
    !(raw_de && raw_hs)
  ) else $error("raw_de high during hsync");

  // the source relies on every read being consumed in the next cycle
  a_rd_then_de: assert property (
    @(posedge clk_50m) disable iff (!locked || !periph_rstn)
    pixel_rd |=> raw_de
  ) else $error("pixel_rd not followed by raw_de");

endmodule

`default_nettype wire

// ==== hdl/vsync_delay.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "video_params.svh"

module vsync_delay (
  input  logic clk_50m,
  input  logic locked,
  input  logic periph_rstn,
  input  logic cam_vs,
  output logic frame_vs
);

  localparam int CNT_W = $clog2(`VS_DELAY);
  // edge is seen one cycle after sampling, output flips one cycle after count 1
  localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(`VS_DELAY - 1);
  localparam logic [CNT_W-1:0] CNT_FIRE = CNT_W'(1);

  logic             vs_ff0;
  logic             vs_ff1;
  logic             vs_rise;
  logic             vs_fall;
  logic [CNT_W-1:0] rise_cnt;  // time left until frame_vs rises
  logic [CNT_W-1:0] fall_cnt;  // time left until frame_vs falls

  // --------------------
  // input sampling
  // --------------------
  always_ff @(posedge clk_50m or negedge locked) begin
    if (!locked) begin
      vs_ff0 <= 1'b0;
      vs_ff1 <= 1'b0;
    end else begin
      vs_ff0 <= cam_vs;
      vs_ff1 <= vs_ff0;
    end
  end

  assign vs_rise = vs_ff0 & ~vs_ff1;
  assign vs_fall = ~vs_ff0 & vs_ff1;

  // --------------------
  // one down-counter per edge direction
  // --------------------
  always_ff @(posedge clk_50m or negedge locked) begin
    if (!locked) begin
      rise_cnt <= '0;
      fall_cnt <= '0;
    end else if (!periph_rstn) begin
      rise_cnt <= '0;
      fall_cnt <= '0;
    end else begin
      if (vs_rise) begin
        rise_cnt <= CNT_LOAD;
      end else if (rise_cnt != '0) begin
        rise_cnt <= rise_cnt - 1'b1;
      end
      if (vs_fall) begin
        fall_cnt <= CNT_LOAD;
      end else if (fall_cnt != '0) begin
        fall_cnt <= fall_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_50m or negedge locked) begin
    if (!locked) begin
      frame_vs <= 1'b0;
    end else if (!periph_rstn) begin
      frame_vs <= 1'b0;
    end else if (rise_cnt == CNT_FIRE) begin
      frame_vs <= 1'b1;
    end else if (fall_cnt == CNT_FIRE) begin
      frame_vs <= 1'b0;
    end
  end

  // same-direction edges closer than the delay would be lost
  a_no_reload: assert property (
    @(posedge clk_50m) disable iff (!locked || !periph_rstn)
    !(vs_rise && rise_cnt != '0) && !(vs_fall && fall_cnt != '0)
  ) else $error("vsync edge arrived while its delay counter was running");

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# A failing check ends the run through $fatal, so the exit status carries the result.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f \
  --top-module tb_video_out \
  -o sim_video_out

./obj_dir/sim_video_out

// ==== sources.f ====
+incdir+hdl
hdl/video_pkg.sv
hdl/periph_reset_gen.sv
hdl/vsync_delay.sv
hdl/video_timing_gen.sv
hdl/rgb565_expand.sv
hdl/param_keys.sv
hdl/video_out_top.sv
tests/tb_video_out.sv

// ==== tests/tb_video_out.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "video_params.svh"

module tb_video_out
  import video_pkg::*;
();

  localparam int HIST_DEPTH  = `VS_DELAY + 2;  // longest look-back of the checks
  localparam int VS_EDGES    = 8;              // even, so cam_vs ends low
  localparam int KEY_PRESSES = 20;
  localparam int KEY_GAP     = 8;
  // roughly twice the expected run
  localparam int TIMEOUT_CYCLES = 2 * (`RESET_DELAY + 4 * `H_TOTAL * `V_TOTAL
                                  + VS_EDGES * 2 * `VS_DELAY + (KEY_PRESSES + 3) * 12);

  logic       clk_50m;
  logic       locked;
  logic       cam_vs;
  rgb565_t    pixel_data = '0;
  logic       key_left;
  logic       key_right;
  logic       key_restore;
  logic       periph_rstn;
  logic       frame_vs;
  logic       pixel_rd;
  logic       hs_out;
  logic       vs_out;
  logic       de_out;
  chan8_t     r_out;
  chan8_t     g_out;
  chan8_t     b_out;
  param_idx_t led_index;

  int          cycle_count = 0;
  logic [31:0] lcg_state = 32'h67d2_45ce;
  rgb565_t     src_q[$];         // pixels handed out, oldest first
  int          pix_cnt = 0;
  logic        rd_pending = 1'b0;  // read strobe of the previous cycle
  logic [23:0] exp_rgb;
  int          key_model = 0;

  // --------------------
  // output monitor state
  // --------------------
  logic hs_d = 1'b0;
  logic de_d = 1'b0;
  logic vs_d = 1'b0;
  logic hs_seen = 1'b0;
  logic vs_seen = 1'b0;
  int   hs_gap = 0;       // cycles since last hsync rise
  int   de_run = 0;
  int   line_runs = 0;    // de runs in the current line
  int   vs_len = 0;
  int   act_lines = 0;
  int   frames_seen = 0;  // complete frames
  logic [1:0]         rd_hist = '0;  // pixel_rd on the last two edges
  logic [`VS_DELAY:0] vs_hist = '0;  // cam_vs on recent edges, newest in bit 0

  video_out_top dut_i (
    .clk_50m     (clk_50m),
    .locked      (locked),
    .cam_vs      (cam_vs),
    .pixel_data  (pixel_data),
    .key_left    (key_left),
    .key_right   (key_right),
    .key_restore (key_restore),
    .periph_rstn (periph_rstn),
    .frame_vs    (frame_vs),
    .pixel_rd    (pixel_rd),
    .hs_out      (hs_out),
    .vs_out      (vs_out),
    .de_out      (de_out),
    .r_out       (r_out),
    .g_out       (g_out),
    .b_out       (b_out),
    .led_index   (led_index)
  );

  always #10 clk_50m = ~clk_50m;

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // each channel refilled from its own top bits
  function automatic logic [23:0] expand_565(input rgb565_t pix);
    logic [4:0] r5;
    logic [5:0] g6;
    logic [4:0] b5;
    r5 = pix[15:11];
    g6 = pix[10:5];
    b5 = pix[4:0];
    return {r5, r5[4:2], g6, g6[5:4], b5, b5[4:2]};
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic press_keys(input logic press_left, input logic press_right,
                            input logic press_restore);
    @(negedge clk_50m);
    key_left    = press_left;
    key_right   = press_right;
    key_restore = press_restore;
    repeat (2) @(negedge clk_50m);
    key_left    = 1'b0;
    key_right   = 1'b0;
    key_restore = 1'b0;
    if (press_restore) begin
      key_model = 0;
    end else if (press_right && !press_left) begin
      key_model = (key_model == `PARAM_COUNT - 1) ? 0 : key_model + 1;
    end else if (press_left && !press_right) begin
      key_model = (key_model == 0) ? `PARAM_COUNT - 1 : key_model - 1;
    end
    repeat (KEY_GAP) @(negedge clk_50m);
    assert (int'(led_index) == key_model)
      else stop_on_error($sformatf("Error keys: expected %0d, actual %0d",
                                   key_model, led_index));
  endtask

  task automatic run_vsync_edges;
    int gap;
    for (int i = 0; i < VS_EDGES; i++) begin
      lcg_state = lcg_step(lcg_state);
      gap = `VS_DELAY + 1 + int'(lcg_state[31:16] % 16'd40);
      repeat (gap) @(negedge clk_50m);
      cam_vs = ~cam_vs;
    end
    repeat (HIST_DEPTH) @(negedge clk_50m);  // last edge reaches frame_vs
  endtask

  task automatic run_key_sequence;
    int pick;
    press_keys(1'b1, 1'b0, 1'b0);  // 0 wraps down to the last slot
    press_keys(1'b0, 1'b1, 1'b0);  // and back up to 0
    for (int i = 0; i < KEY_PRESSES; i++) begin
      lcg_state = lcg_step(lcg_state);
      pick = int'(lcg_state[31:29]);
      case (pick)
        0, 1, 2: press_keys(1'b0, 1'b1, 1'b0);
        3, 4, 5: press_keys(1'b1, 1'b0, 1'b0);
        6:       press_keys(1'b1, 1'b1, 1'b0);  // both cancel
        default: press_keys(1'b0, 1'b1, 1'b1);  // restore wins
      endcase
    end
    press_keys(1'b0, 1'b0, 1'b1);
  endtask

  // --------------------
  // pixel source, one value in the cycle after each read strobe
  // --------------------
  always @(negedge clk_50m) begin
    if (rd_pending) begin
      pixel_data = rgb565_t'(pix_cnt * 16'h9e37);
      src_q.push_back(pixel_data);
      pix_cnt++;
    end
    rd_pending = pixel_rd;
  end

  always @(posedge clk_50m) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      stop_on_error("timeout, the tests did not finish in time");
    end
  end

  always @(posedge clk_50m) begin
    rd_hist <= {rd_hist[0], pixel_rd};
    vs_hist <= {vs_hist[`VS_DELAY-1:0], cam_vs};
  end

  always @(posedge clk_50m) begin
    if (locked) begin
      hs_d   <= hs_out;
      de_d   <= de_out;
      vs_d   <= vs_out;
      de_run <= de_out ? de_run + 1 : 0;
      vs_len <= vs_out ? vs_len + 1 : 0;
      if (hs_out && !hs_d) begin
        hs_gap    <= 1;
        hs_seen   <= 1'b1;
        line_runs <= 0;
      end else begin
        hs_gap <= hs_gap + 1;
      end
      if (de_out && !de_d) line_runs <= line_runs + 1;
      if (vs_out && !vs_d) begin
        act_lines <= 0;
        vs_seen   <= 1'b1;
        if (vs_seen) frames_seen <= frames_seen + 1;
      end else if (de_out && !de_d) begin
        act_lines <= act_lines + 1;
      end
      if (de_out) begin
        assert (src_q.size() > 0)
          else stop_on_error("data enable came with no source pixel left to show");
        exp_rgb = expand_565(src_q.pop_front());
        assert ({r_out, g_out, b_out} == exp_rgb)
          else stop_on_error($sformatf("Error pixel: expected %06h, actual %06h",
                                       exp_rgb, {r_out, g_out, b_out}));
      end
    end
  end

  // --------------------
  // concurrent checks
  // --------------------
  a_reset_state: assert property (@(posedge clk_50m)
    !locked && cycle_count > 0 |-> !periph_rstn && !frame_vs && !pixel_rd && !hs_out
                                   && !vs_out && !de_out && led_index == '0
  ) else stop_on_error("an output was active while locked was low");

  a_release_time: assert property (@(posedge clk_50m)
    $rose(periph_rstn) |-> $past(locked, `RESET_DELAY + 2) && !$past(locked, `RESET_DELAY + 3)
  ) else stop_on_error("periph_rstn rose at the wrong cycle after lock");

  a_line_period: assert property (@(posedge clk_50m) disable iff (!locked)
    $rose(hs_out) && hs_seen |-> hs_gap == `H_TOTAL
  ) else stop_on_error($sformatf("Error timing: expected line %0d, actual %0d",
                                 `H_TOTAL, $sampled(hs_gap)));

  a_de_run: assert property (@(posedge clk_50m) disable iff (!locked)
    (!$fell(de_out) || de_run == `H_ACT) && (!de_out || de_run < `H_ACT)
  ) else stop_on_error($sformatf("Error timing: expected de run %0d, actual %0d",
                                 `H_ACT, $sampled(de_run)));

  a_one_run_per_line: assert property (@(posedge clk_50m) disable iff (!locked)
    $rose(de_out) |-> line_runs == 0
  ) else stop_on_error("a second de_out run started inside one line");

  a_active_lines: assert property (@(posedge clk_50m) disable iff (!locked)
    $rose(vs_out) && vs_seen |-> act_lines == `V_ACT
  ) else stop_on_error($sformatf("Error timing: expected %0d active lines, actual %0d",
                                 `V_ACT, $sampled(act_lines)));

  a_vsync_width: assert property (@(posedge clk_50m) disable iff (!locked)
    $fell(vs_out) |-> vs_len == `V_SYNC * `H_TOTAL
  ) else stop_on_error($sformatf("Error timing: expected vsync %0d, actual %0d",
                                 `V_SYNC * `H_TOTAL, $sampled(vs_len)));

  a_de_hs_apart: assert property (@(posedge clk_50m) disable iff (!locked)
    !(de_out && hs_out)
  ) else stop_on_error("de_out was high during hs_out");

  a_rd_to_de: assert property (@(posedge clk_50m) disable iff (!locked)
    cycle_count >= HIST_DEPTH |-> de_out == rd_hist[1]
  ) else stop_on_error($sformatf("Error pipeline: expected de_out %0b, actual %0b",
                                 $sampled(rd_hist[1]), $sampled(de_out)));

  a_blank_black: assert property (@(posedge clk_50m) disable iff (!locked)
    !de_out |-> {r_out, g_out, b_out} == 24'h0
  ) else stop_on_error($sformatf("Error blanking: expected 000000, actual %06h",
                                 $sampled({r_out, g_out, b_out})));

  a_vsync_delay: assert property (@(posedge clk_50m) disable iff (!locked)
    cycle_count >= HIST_DEPTH |-> frame_vs == vs_hist[`VS_DELAY]
  ) else stop_on_error($sformatf("Error vsync: expected frame_vs %0b, actual %0b",
                                 $sampled(vs_hist[`VS_DELAY]), $sampled(frame_vs)));

  initial begin
    clk_50m     = 1'b0;
    locked      = 1'b0;
    cam_vs      = 1'b0;
    key_left    = 1'b0;
    key_right   = 1'b0;
    key_restore = 1'b0;
    repeat (2) @(posedge clk_50m);
    @(negedge clk_50m);
    locked = 1'b1;
    repeat (`RESET_DELAY + 2) @(negedge clk_50m);
    assert (periph_rstn) else stop_on_error("periph_rstn was not released after the delay");

    run_vsync_edges();
    run_key_sequence();
    while (frames_seen < 3) @(negedge clk_50m);  // video checks keep running

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire
